// File: axis_fifo_pkg.sv
// shared sizes for the dual-clock AXI4-Stream FIFO
// referenced through scoped names by every design file
package axis_fifo_pkg;

    // memory address bits
    localparam int ADDR_WIDTH = 5;

    // number of stored beats
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // stream payload widths
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // one stored beat packed as tlast, tuser, tkeep, tdata
    localparam int BEAT_WIDTH = DATA_WIDTH + KEEP_WIDTH + 2;

    // the extra msb tells full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

endpackage

// File: axis_fifo_rst_sync.sv
// reset synchronizer for both FIFO clock domains
// asserts asynchronously, releases each domain on its own clock
`timescale 1ns/1ps

module axis_fifo_rst_sync (
    input  logic async_rst,
    input  logic input_clk,
    input  logic output_clk,
    output logic input_rst,
    output logic output_rst
);

    logic input_rst_sync1;
    logic input_rst_sync2;
    logic output_rst_sync1;
    logic output_rst_sync2;

    // write side stays in reset until the read chain starts to release
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            input_rst_sync1 <= 1'b1;
            input_rst_sync2 <= 1'b1;
            input_rst       <= 1'b1;
        end else begin
            input_rst_sync1 <= 1'b0;
            input_rst_sync2 <= input_rst_sync1 | output_rst_sync1;
            input_rst       <= input_rst_sync2;
        end
    end

    // read side releases after three edges
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            output_rst_sync1 <= 1'b1;
            output_rst_sync2 <= 1'b1;
            output_rst       <= 1'b1;
        end else begin
            output_rst_sync1 <= 1'b0;
            output_rst_sync2 <= output_rst_sync1;
            output_rst       <= output_rst_sync2;
        end
    end

endmodule

// File: axis_fifo_ram.sv
// dual-clock beat memory, written on input_clk and read on output_clk
// the read register doubles as the FIFO output data register
`timescale 1ns/1ps

module axis_fifo_ram (
    input  logic                                  input_clk,
    input  logic                                  output_clk,
    input  logic                                  wr_en,
    input  logic [axis_fifo_pkg::ADDR_WIDTH-1:0]  wr_addr,
    input  logic [axis_fifo_pkg::BEAT_WIDTH-1:0]  wr_beat,
    input  logic                                  rd_en,
    input  logic [axis_fifo_pkg::ADDR_WIDTH-1:0]  rd_addr,
    output logic [axis_fifo_pkg::BEAT_WIDTH-1:0]  rd_beat
);

    logic [axis_fifo_pkg::BEAT_WIDTH-1:0] mem [axis_fifo_pkg::DEPTH];

    // write port
    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // read port holds its beat until the next read
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

// File: axis_fifo_wr_ctrl.sv
// write-side control of the async FIFO with pointers, full flag and input ready
// the read pointer arrives Gray coded from the output_clk domain
`timescale 1ns/1ps

module axis_fifo_wr_ctrl (
    input  logic                                 input_clk,
    input  logic                                 input_rst,
    input  logic                                 tvalid,
    output logic                                 tready,
    input  logic [axis_fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray,
    output logic                                 wr_en,
    output logic [axis_fifo_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [axis_fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray
);

    logic [axis_fifo_pkg::PTR_WIDTH-1:0] wr_ptr;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] wr_ptr_next;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] rd_ptr_gray_sync1;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] rd_ptr_gray_sync2;
    logic                                full;

    // Gray equivalent of "msb differs, rest equal"
    assign full = (wr_ptr_gray[axis_fifo_pkg::PTR_WIDTH-1 -: 2] ==
                   ~rd_ptr_gray_sync2[axis_fifo_pkg::PTR_WIDTH-1 -: 2]) &&
                  (wr_ptr_gray[axis_fifo_pkg::ADDR_WIDTH-2:0] ==
                   rd_ptr_gray_sync2[axis_fifo_pkg::ADDR_WIDTH-2:0]);

    assign tready      = ~full & ~input_rst;
    assign wr_en       = tvalid & tready;
    assign wr_addr     = wr_ptr[axis_fifo_pkg::ADDR_WIDTH-1:0];
    assign wr_ptr_next = wr_ptr + 1'b1;

    // two-flop crossing of the read pointer
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            rd_ptr_gray_sync1 <= '0;
            rd_ptr_gray_sync2 <= '0;
        end else begin
            rd_ptr_gray_sync1 <= rd_ptr_gray;
            rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
        end
    end

    // advance on every accepted beat
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_en) begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

endmodule

// File: axis_fifo_rd_ctrl.sv
// read-side control of the async FIFO with pointers, empty flag and output valid
// the write pointer arrives Gray coded from the input_clk domain
`timescale 1ns/1ps

module axis_fifo_rd_ctrl (
    input  logic                                 output_clk,
    input  logic                                 output_rst,
    input  logic                                 tready,
    output logic                                 tvalid,
    input  logic [axis_fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray,
    output logic                                 rd_en,
    output logic [axis_fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic [axis_fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray
);

    logic [axis_fifo_pkg::PTR_WIDTH-1:0] rd_ptr;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] rd_ptr_next;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] wr_ptr_gray_sync1;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0] wr_ptr_gray_sync2;
    logic                                empty;
    logic                                out_free;

    // pointers match exactly when nothing is stored
    assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

    // output register is empty or being taken this cycle
    assign out_free = tready | ~tvalid;

    assign rd_en       = out_free & ~empty;
    assign rd_addr     = rd_ptr[axis_fifo_pkg::ADDR_WIDTH-1:0];
    assign rd_ptr_next = rd_ptr + 1'b1;

    // two-flop crossing of the write pointer
    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            wr_ptr_gray_sync1 <= '0;
            wr_ptr_gray_sync2 <= '0;
        end else begin
            wr_ptr_gray_sync1 <= wr_ptr_gray;
            wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
        end
    end

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_en) begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
        end
    end

    // valid follows the load of the memory read register;
    // while the consumer stalls, it holds
    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            tvalid <= 1'b0;
        end else if (out_free) begin
            tvalid <= ~empty;
        end
    end

endmodule

// File: axis_async_fifo_64.sv
// dual-clock AXI4-Stream FIFO, 64-bit data with tkeep, tlast and tuser
// beats enter on input_clk and leave on output_clk
`timescale 1ns/1ps

module axis_async_fifo_64 (
    input  logic                                  async_rst,

    input  logic                                  input_clk,
    input  logic [axis_fifo_pkg::DATA_WIDTH-1:0]  input_axis_tdata,
    input  logic [axis_fifo_pkg::KEEP_WIDTH-1:0]  input_axis_tkeep,
    input  logic                                  input_axis_tvalid,
    output logic                                  input_axis_tready,
    input  logic                                  input_axis_tlast,
    input  logic                                  input_axis_tuser,

    input  logic                                  output_clk,
    output logic [axis_fifo_pkg::DATA_WIDTH-1:0]  output_axis_tdata,
    output logic [axis_fifo_pkg::KEEP_WIDTH-1:0]  output_axis_tkeep,
    output logic                                  output_axis_tvalid,
    input  logic                                  output_axis_tready,
    output logic                                  output_axis_tlast,
    output logic                                  output_axis_tuser
);

    logic                                 input_rst;
    logic                                 output_rst;
    logic                                 wr_en;
    logic                                 rd_en;
    logic [axis_fifo_pkg::ADDR_WIDTH-1:0] wr_addr;
    logic [axis_fifo_pkg::ADDR_WIDTH-1:0] rd_addr;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray;
    logic [axis_fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray;
    logic [axis_fifo_pkg::BEAT_WIDTH-1:0] write_beat;
    logic [axis_fifo_pkg::BEAT_WIDTH-1:0] read_beat;

    // beat layout is tlast, tuser, tkeep, tdata from msb down
    assign write_beat = {input_axis_tlast, input_axis_tuser, input_axis_tkeep, input_axis_tdata};
    assign {output_axis_tlast, output_axis_tuser, output_axis_tkeep, output_axis_tdata} = read_beat;

    axis_fifo_rst_sync rst_sync_i (
        .async_rst  (async_rst),
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .input_rst  (input_rst),
        .output_rst (output_rst)
    );

    axis_fifo_wr_ctrl wr_ctrl_i (
        .input_clk   (input_clk),
        .input_rst   (input_rst),
        .tvalid      (input_axis_tvalid),
        .tready      (input_axis_tready),
        .rd_ptr_gray (rd_ptr_gray),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_ptr_gray (wr_ptr_gray)
    );

    axis_fifo_rd_ctrl rd_ctrl_i (
        .output_clk  (output_clk),
        .output_rst  (output_rst),
        .tready      (output_axis_tready),
        .tvalid      (output_axis_tvalid),
        .wr_ptr_gray (wr_ptr_gray),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_ptr_gray (rd_ptr_gray)
    );

    axis_fifo_ram ram_i (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_beat    (write_beat),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_beat    (read_beat)
    );

endmodule

// File: axis_async_fifo_64_assert.sv
// concurrent handshake and reset checks for the dual-clock stream FIFO
// bound into the FIFO top level
`timescale 1ns/1ps

module axis_async_fifo_64_assert (
    input logic                                 async_rst,
    input logic                                 input_clk,
    input logic                                 input_axis_tready,
    input logic                                 output_clk,
    input logic                                 output_axis_tvalid,
    input logic                                 output_axis_tready,
    input logic [axis_fifo_pkg::DATA_WIDTH-1:0] output_axis_tdata,
    input logic [axis_fifo_pkg::KEEP_WIDTH-1:0] output_axis_tkeep,
    input logic                                 output_axis_tlast,
    input logic                                 output_axis_tuser
);

    // failures seen by the assertions below
    int fail_count = 0;

    // a stalled beat stays valid and unchanged
    property hold_under_backpressure;
        @(posedge output_clk) disable iff (async_rst)
            output_axis_tvalid && !output_axis_tready |=>
                output_axis_tvalid && $stable(output_axis_tdata) &&
                $stable(output_axis_tkeep) && $stable(output_axis_tlast) &&
                $stable(output_axis_tuser);
    endproperty

    assert property (hold_under_backpressure)
        else begin
            fail_count++;
            $error("output beat changed or dropped while stalled");
        end

    assert property (@(posedge input_clk) async_rst |-> !input_axis_tready)
        else begin
            fail_count++;
            $error("input ready high during reset");
        end

    assert property (@(posedge output_clk) async_rst |-> !output_axis_tvalid)
        else begin
            fail_count++;
            $error("output valid high during reset");
        end

endmodule

bind axis_async_fifo_64 axis_async_fifo_64_assert assert_i (
    .async_rst          (async_rst),
    .input_clk          (input_clk),
    .input_axis_tready  (input_axis_tready),
    .output_clk         (output_clk),
    .output_axis_tvalid (output_axis_tvalid),
    .output_axis_tready (output_axis_tready),
    .output_axis_tdata  (output_axis_tdata),
    .output_axis_tkeep  (output_axis_tkeep),
    .output_axis_tlast  (output_axis_tlast),
    .output_axis_tuser  (output_axis_tuser)
);

// File: axis_async_fifo_64_tb.sv
// testbench for the dual-clock AXI4-Stream FIFO
// runs a table of packet rows through a scoreboard, with gaps and stalls
`timescale 1ns/1ps

module axis_async_fifo_64_tb;

    typedef struct {
        int         packets;
        int         beats;
        logic [7:0] last_keep;
        logic       user;
        int         gap_pct;
        int         ready_low_pct;
        int         stall_cycles;
    } row_t;

    localparam int          NUM_ROWS = 5;
    localparam logic [31:0] SEED     = 32'h8b70e37b;

    logic                                 async_rst;
    logic                                 input_clk;
    logic                                 output_clk;
    logic [axis_fifo_pkg::DATA_WIDTH-1:0] input_axis_tdata;
    logic [axis_fifo_pkg::KEEP_WIDTH-1:0] input_axis_tkeep;
    logic                                 input_axis_tvalid;
    logic                                 input_axis_tready;
    logic                                 input_axis_tlast;
    logic                                 input_axis_tuser;
    logic [axis_fifo_pkg::DATA_WIDTH-1:0] output_axis_tdata;
    logic [axis_fifo_pkg::KEEP_WIDTH-1:0] output_axis_tkeep;
    logic                                 output_axis_tvalid;
    logic                                 output_axis_tready;
    logic                                 output_axis_tlast;
    logic                                 output_axis_tuser;

    row_t                                 rows [NUM_ROWS];
    logic [axis_fifo_pkg::BEAT_WIDTH-1:0] expected_q [$];
    logic [31:0]                          wr_rand;
    logic [31:0]                          rd_rand;
    int error_count   = 0;
    int timeout_count = 0;
    int received      = 0;
    int row_accepted  = 0;
    int total_beats   = 0;
    int cycle_count   = 0;
    int cycle_limit   = 0;

    axis_async_fifo_64 axis_async_fifo_64_i (
        .async_rst          (async_rst),
        .input_clk          (input_clk),
        .input_axis_tdata   (input_axis_tdata),
        .input_axis_tkeep   (input_axis_tkeep),
        .input_axis_tvalid  (input_axis_tvalid),
        .input_axis_tready  (input_axis_tready),
        .input_axis_tlast   (input_axis_tlast),
        .input_axis_tuser   (input_axis_tuser),
        .output_clk         (output_clk),
        .output_axis_tdata  (output_axis_tdata),
        .output_axis_tkeep  (output_axis_tkeep),
        .output_axis_tvalid (output_axis_tvalid),
        .output_axis_tready (output_axis_tready),
        .output_axis_tlast  (output_axis_tlast),
        .output_axis_tuser  (output_axis_tuser)
    );

    initial begin
        input_clk = 1'b0;
        forever #5 input_clk = ~input_clk;
    end

    initial begin
        output_clk = 1'b0;
        forever #7 output_clk = ~output_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = axis_async_fifo_64_i.assert_i.fail_count;
        $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
                 error_count, assert_fails, timeout_count);
        if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // offers the row's beats, each held until it transfers
    task automatic send_row(input row_t row);
        int          total;
        int          sent;
        int          in_packet;
        logic        pending;
        logic [31:0] upper;
        total   = row.packets * row.beats;
        sent    = 0;
        pending = 1'b0;
        while (sent < total) begin
            @(posedge input_clk);
            if (pending && input_axis_tready) begin
                pending = 1'b0;
                sent++;
            end
            if (!pending && sent < total) begin
                wr_rand = lcg_next(wr_rand);
                if (wr_rand[31:8] % 100 < row.gap_pct) begin
                    input_axis_tvalid <= 1'b0;
                end else begin
                    in_packet = sent % row.beats;
                    wr_rand   = lcg_next(wr_rand);
                    upper     = wr_rand;
                    wr_rand   = lcg_next(wr_rand);
                    input_axis_tdata  <= {upper, wr_rand};
                    input_axis_tkeep  <= (in_packet == row.beats - 1) ? row.last_keep : 8'hff;
                    input_axis_tlast  <= (in_packet == row.beats - 1);
                    input_axis_tuser  <= row.user;
                    input_axis_tvalid <= 1'b1;
                    pending = 1'b1;
                end
            end
        end
        input_axis_tvalid <= 1'b0;
    endtask

    // optional stall first, then random ready until the row is drained
    task automatic receive_row(input row_t row);
        int target;
        target = received + row.packets * row.beats;
        repeat (row.stall_cycles) begin
            @(posedge output_clk);
            output_axis_tready <= 1'b0;
        end
        if (row.stall_cycles > 0) begin
            @(negedge output_clk);
            check_value(row_accepted, axis_fifo_pkg::DEPTH + 1, "beats accepted during stall");
            check_value(input_axis_tready, 1'b0, "input ready at full");
        end
        while (received < target) begin
            @(posedge output_clk);
            rd_rand = lcg_next(rd_rand);
            output_axis_tready <= (rd_rand[31:8] % 100 >= row.ready_low_pct);
            @(negedge output_clk);
        end
    endtask

    // scoreboard push on every accepted input beat
    always @(posedge input_clk) begin
        if (!async_rst && input_axis_tvalid && input_axis_tready) begin
            expected_q.push_back({input_axis_tlast, input_axis_tuser,
                                  input_axis_tkeep, input_axis_tdata});
            row_accepted++;
        end
    end

    always @(posedge output_clk) begin
        logic [axis_fifo_pkg::BEAT_WIDTH-1:0] exp_beat;
        if (!async_rst && output_axis_tvalid && output_axis_tready) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("output beat at %0t arrived when no beat was expected", $time);
            end else begin
                exp_beat = expected_q.pop_front();
                check_value(output_axis_tdata, exp_beat[axis_fifo_pkg::DATA_WIDTH-1:0], "tdata");
                check_value(output_axis_tkeep,
                            exp_beat[axis_fifo_pkg::DATA_WIDTH +: axis_fifo_pkg::KEEP_WIDTH],
                            "tkeep");
                check_value(output_axis_tuser, exp_beat[axis_fifo_pkg::BEAT_WIDTH-2], "tuser");
                check_value(output_axis_tlast, exp_beat[axis_fifo_pkg::BEAT_WIDTH-1], "tlast");
            end
            received++;
        end
    end

    always @(posedge input_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            timeout_count++;
            $display("run timed out after %0d input cycles with %0d beats still missing",
                     cycle_count, total_beats - received);
            finish_run();
        end
    end

    initial begin
        int   stall_total;
        int   wait_cycles;
        logic ready_seen;
        async_rst          = 1'b1;
        input_axis_tdata   = '0;
        input_axis_tkeep   = '0;
        input_axis_tvalid  = 1'b0;
        input_axis_tlast   = 1'b0;
        input_axis_tuser   = 1'b0;
        output_axis_tready = 1'b0;
        wr_rand            = SEED;
        rd_rand            = ~SEED;

        // packets, beats, last keep, user, gap %, ready low %, stall
        rows[0] = '{4, 1, 8'h01, 1'b0, 0, 0, 0};
        rows[1] = '{3, 5, 8'h0f, 1'b1, 0, 0, 0};
        rows[2] = '{1, 40, 8'hff, 1'b0, 0, 0, 64};
        rows[3] = '{10, 4, 8'h3f, 1'b1, 30, 30, 0};
        rows[4] = '{6, 7, 8'h07, 1'b0, 50, 60, 0};

        stall_total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_beats += rows[r].packets * rows[r].beats;
            stall_total += rows[r].stall_cycles;
        end
        cycle_limit = 20 * total_beats + stall_total + 200;

        repeat (3) @(posedge input_clk);
        @(negedge input_clk);
        check_value(input_axis_tready, 1'b0, "input ready in reset");
        check_value(output_axis_tvalid, 1'b0, "output valid in reset");
        @(posedge input_clk);
        async_rst <= 1'b0;

        ready_seen = 1'b0;
        for (wait_cycles = 0; wait_cycles < 10 && !ready_seen; wait_cycles++) begin
            @(negedge input_clk);
            ready_seen = input_axis_tready;
        end
        if (!ready_seen) begin
            error_count++;
            $display("input ready did not rise within 10 cycles after reset release");
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_accepted = 0;
            fork
                send_row(rows[r]);
                receive_row(rows[r]);
            join
        end

        // nothing left over or duplicated
        repeat (5) @(posedge output_clk);
        check_value(expected_q.size(), 0, "scoreboard entries left");
        check_value(received, total_beats, "beats received");
        finish_run();
    end

endmodule

// File: list.f
axis_fifo_pkg.sv
axis_fifo_rst_sync.sv
axis_fifo_ram.sv
axis_fifo_wr_ctrl.sv
axis_fifo_rd_ctrl.sv
axis_async_fifo_64.sv
axis_async_fifo_64_assert.sv
axis_async_fifo_64_tb.sv
